// File: design/fetch_pkg.sv
package fetch_pkg;

    // machine word, used for pcs, targets and instruction words
    localparam int xlen = 32;

    // exception code field as carried down the pipe
    localparam int exc_code_w = 5;

    // instruction fetch from a misaligned address
    localparam logic [exc_code_w-1:0] exc_adel = 5'd4;

    // boot rom entry point, overridable from the top
    localparam logic [xlen-1:0] default_reset_pc = 32'hbfc00000;

    // general exception entry taken on a flush
    localparam logic [xlen-1:0] exc_vector = 32'hbfc00380;

    // btb depth, must be a power of two
    localparam int default_btb_entries = 16;

endpackage

// File: design/bpu.sv
`timescale 1ns/1ps

module bpu #(
    parameter int btb_entries = fetch_pkg::default_btb_entries
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [fetch_pkg::xlen-1:0] fs_pc,
    input  logic                       br_valid,
    input  logic [fetch_pkg::xlen-1:0] br_pc,
    input  logic                       br_taken,
    input  logic [fetch_pkg::xlen-1:0] br_target,
    output logic                       pred_taken,
    output logic [fetch_pkg::xlen-1:0] pred_target
);

    import fetch_pkg::*;

    localparam int idx_w = $clog2(btb_entries);
    // word offset bits are not part of index or tag
    localparam int tag_w = xlen - idx_w - 2;

    logic [btb_entries-1:0] valid_r;
    logic [tag_w-1:0]       tag_r    [btb_entries];
    logic [xlen-1:0]        target_r [btb_entries];
    logic [1:0]             cnt_r    [btb_entries];

    logic [idx_w-1:0] rd_idx;
    logic [tag_w-1:0] rd_tag;
    logic             rd_hit;
    logic [idx_w-1:0] wr_idx;
    logic [tag_w-1:0] wr_tag;
    logic             wr_hit;

    // lookup for the pc in fetch
    assign rd_idx = fs_pc[idx_w+1:2];
    assign rd_tag = fs_pc[xlen-1:idx_w+2];
    assign rd_hit = valid_r[rd_idx] && (tag_r[rd_idx] == rd_tag);

    // weakly or strongly taken
    assign pred_taken  = rd_hit && cnt_r[rd_idx][1];
    // not taken falls through to the next word
    assign pred_target = pred_taken ? target_r[rd_idx] : fs_pc + xlen'(4);

    // training port, driven by the resolved branch
    assign wr_idx = br_pc[idx_w+1:2];
    assign wr_tag = br_pc[xlen-1:idx_w+2];
    assign wr_hit = valid_r[wr_idx] && (tag_r[wr_idx] == wr_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= '0;
        end else if (br_valid && br_taken && !wr_hit) begin
            valid_r[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (br_valid) begin
            if (wr_hit) begin
                if (br_taken) begin
                    target_r[wr_idx] <= br_target;
                    if (cnt_r[wr_idx] != 2'd3) begin
                        cnt_r[wr_idx] <= cnt_r[wr_idx] + 2'd1;
                    end
                end else if (cnt_r[wr_idx] != 2'd0) begin
                    cnt_r[wr_idx] <= cnt_r[wr_idx] - 2'd1;
                end
            end else if (br_taken) begin
                // new entry starts weakly taken
                tag_r[wr_idx]    <= wr_tag;
                target_r[wr_idx] <= br_target;
                cnt_r[wr_idx]    <= 2'd2;
            end
        end
    end

endmodule

// File: design/pre_if_stage.sv
`timescale 1ns/1ps

module pre_if_stage #(
    parameter logic [fetch_pkg::xlen-1:0] reset_pc = fetch_pkg::default_reset_pc
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             flush,
    input  logic                             br_mispredict,
    input  logic [fetch_pkg::xlen-1:0]       br_target,
    input  logic                             pred_valid,
    input  logic [fetch_pkg::xlen-1:0]       pred_target,
    input  logic                             fs_allowin,
    output logic                             inst_req,
    output logic [fetch_pkg::xlen-1:0]       inst_addr,
    output logic                             ps_to_fs_valid,
    output logic [fetch_pkg::xlen-1:0]       ps_pc,
    output logic                             ps_ex,
    output logic [fetch_pkg::exc_code_w-1:0] ps_exc_code
);

    import fetch_pkg::*;

    // sequential pc following the instruction now in fetch
    logic [xlen-1:0] pc_r;
    // address actually requested this cycle
    logic [xlen-1:0] fetch_pc;

    // a taken prediction for the pc in fetch overrides the sequential pc
    assign fetch_pc = pred_valid ? pred_target : pc_r;

    // one request per slot that fetch can take
    assign inst_req  = fs_allowin & ~reset;
    assign inst_addr = fetch_pc;

    // every issued request moves on to fetch in the same cycle
    assign ps_to_fs_valid = inst_req;
    assign ps_pc          = fetch_pc;

    // misaligned pc still goes out, the word is dropped in fetch
    assign ps_ex       = |fetch_pc[1:0];
    assign ps_exc_code = ps_ex ? exc_adel : '0;

    // redirects win over the normal advance
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_r <= reset_pc;
        end else if (flush) begin
            pc_r <= exc_vector;
        end else if (br_mispredict) begin
            pc_r <= br_target;
        end else if (inst_req) begin
            pc_r <= fetch_pc + xlen'(4);
        end
    end

endmodule

// File: design/if_stage.sv
`timescale 1ns/1ps

module if_stage #(
    parameter int btb_entries = fetch_pkg::default_btb_entries
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             flush,
    input  logic                             br_mispredict,
    input  logic                             ps_to_fs_valid,
    input  logic [fetch_pkg::xlen-1:0]       ps_pc,
    input  logic                             ps_ex,
    input  logic [fetch_pkg::exc_code_w-1:0] ps_exc_code,
    input  logic                             ds_allowin,
    input  logic                             icache_busy,
    input  logic [fetch_pkg::xlen-1:0]       inst_rdata,
    input  logic                             br_valid,
    input  logic [fetch_pkg::xlen-1:0]       br_pc,
    input  logic                             br_taken,
    input  logic [fetch_pkg::xlen-1:0]       br_target,
    output logic                             fs_allowin,
    output logic                             pred_valid,
    output logic [fetch_pkg::xlen-1:0]       pred_target,
    output logic                             fs_to_ds_valid,
    output logic [fetch_pkg::xlen-1:0]       fs_pc,
    output logic [fetch_pkg::xlen-1:0]       fs_inst,
    output logic                             fs_ex,
    output logic [fetch_pkg::exc_code_w-1:0] fs_exc_code,
    output logic                             fs_pred_taken,
    output logic [fetch_pkg::xlen-1:0]       fs_pred_target
);

    import fetch_pkg::*;

    logic                  fs_valid;
    logic                  fs_load;
    logic                  redirect;
    logic [xlen-1:0]       fs_pc_r;
    logic                  fs_ex_r;
    logic [exc_code_w-1:0] fs_exc_code_r;
    logic                  bpu_taken;
    logic [xlen-1:0]       bpu_target;

    // either redirect kills the instruction in flight
    assign redirect = flush | br_mispredict;

    // stage is done once the icache stops stalling
    assign fs_allowin     = ~fs_valid | (~icache_busy & ds_allowin);
    assign fs_to_ds_valid = fs_valid & ~icache_busy;
    assign fs_load        = ps_to_fs_valid & fs_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (redirect) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= ps_to_fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_ex_r <= 1'b0;
        end else if (fs_load) begin
            fs_ex_r <= ps_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_load) begin
            fs_pc_r       <= ps_pc;
            fs_exc_code_r <= ps_exc_code;
        end
    end

    assign fs_pc       = fs_pc_r;
    assign fs_ex       = fs_ex_r;
    assign fs_exc_code = fs_exc_code_r;
    // a faulting fetch hands a nop to decode
    assign fs_inst     = fs_ex_r ? '0 : inst_rdata;

    // prediction only counts while a real instruction sits here
    assign pred_valid     = fs_valid & bpu_taken;
    assign pred_target    = bpu_target;
    assign fs_pred_taken  = pred_valid;
    assign fs_pred_target = bpu_target;

    bpu #(
        .btb_entries (btb_entries)
    ) u_bpu (
        .clk         (clk),
        .reset       (reset),
        .fs_pc       (fs_pc_r),
        .br_valid    (br_valid),
        .br_pc       (br_pc),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .pred_taken  (bpu_taken),
        .pred_target (bpu_target)
    );

endmodule

// File: design/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend #(
    parameter logic [fetch_pkg::xlen-1:0] reset_pc    = fetch_pkg::default_reset_pc,
    parameter int                         btb_entries = fetch_pkg::default_btb_entries
) (
    input  logic                             clk,
    input  logic                             reset,
    // instruction memory
    output logic                             inst_req,
    output logic [fetch_pkg::xlen-1:0]       inst_addr,
    input  logic [fetch_pkg::xlen-1:0]       inst_rdata,
    input  logic                             icache_busy,
    // decode
    output logic                             fs_to_ds_valid,
    output logic [fetch_pkg::xlen-1:0]       fs_pc,
    output logic [fetch_pkg::xlen-1:0]       fs_inst,
    output logic                             fs_ex,
    output logic [fetch_pkg::exc_code_w-1:0] fs_exc_code,
    output logic                             fs_pred_taken,
    output logic [fetch_pkg::xlen-1:0]       fs_pred_target,
    input  logic                             ds_allowin,
    // back end
    input  logic                             flush,
    input  logic                             br_valid,
    input  logic [fetch_pkg::xlen-1:0]       br_pc,
    input  logic                             br_taken,
    input  logic [fetch_pkg::xlen-1:0]       br_target,
    input  logic                             br_mispredict
);

    import fetch_pkg::*;

    logic                  ps_to_fs_valid;
    logic [xlen-1:0]       ps_pc;
    logic                  ps_ex;
    logic [exc_code_w-1:0] ps_exc_code;
    logic                  fs_allowin;
    logic                  pred_valid;
    logic [xlen-1:0]       pred_target;

    pre_if_stage #(
        .reset_pc (reset_pc)
    ) u_pre_if_stage (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .br_mispredict  (br_mispredict),
        .br_target      (br_target),
        .pred_valid     (pred_valid),
        .pred_target    (pred_target),
        .fs_allowin     (fs_allowin),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .ps_to_fs_valid (ps_to_fs_valid),
        .ps_pc          (ps_pc),
        .ps_ex          (ps_ex),
        .ps_exc_code    (ps_exc_code)
    );

    if_stage #(
        .btb_entries (btb_entries)
    ) u_if_stage (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .br_mispredict  (br_mispredict),
        .ps_to_fs_valid (ps_to_fs_valid),
        .ps_pc          (ps_pc),
        .ps_ex          (ps_ex),
        .ps_exc_code    (ps_exc_code),
        .ds_allowin     (ds_allowin),
        .icache_busy    (icache_busy),
        .inst_rdata     (inst_rdata),
        .br_valid       (br_valid),
        .br_pc          (br_pc),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .fs_allowin     (fs_allowin),
        .pred_valid     (pred_valid),
        .pred_target    (pred_target),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .fs_ex          (fs_ex),
        .fs_exc_code    (fs_exc_code),
        .fs_pred_taken  (fs_pred_taken),
        .fs_pred_target (fs_pred_target)
    );

endmodule

// File: verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    import fetch_pkg::*;

    localparam int btb_n = 16;
    localparam int idx_w = $clog2(btb_n);
    localparam int mode_seq = 0;
    localparam int mode_pred = 1;
    localparam int mode_misp = 2;
    localparam int mode_flush = 3;
    localparam int mode_adel = 4;
    localparam int seq_cycles = 300;
    localparam int pred_cycles = 500;
    localparam int misp_cycles = 300;
    localparam int flush_cycles = 250;
    localparam int adel_cycles = 200;
    // reset and first-delivery wait are budgeted as 30 cycles
    localparam int total_cycles = 30 + seq_cycles + pred_cycles + misp_cycles
                                  + flush_cycles + adel_cycles;
    localparam int cycle_limit = 4 * total_cycles + 100;

    logic clk, reset, inst_req, icache_busy, ds_allowin, fs_to_ds_valid, fs_ex;
    logic fs_pred_taken, flush, br_valid, br_taken, br_mispredict;
    logic [31:0] inst_addr, inst_rdata, fs_pc, fs_inst, fs_pred_target, br_pc, br_target;
    logic [4:0] fs_exc_code;

    // reference model state
    logic [31:0] exp_pc, last_pc, mem_addr, first_fs_pc, held_pc, held_inst;
    logic        m_valid [btb_n];
    logic [31:0] m_tag [btb_n];
    logic [31:0] m_target [btb_n];
    logic [1:0]  m_cnt [btb_n];
    // set by a redirect and cleared by the next delivery
    logic        squashed;
    logic        hold_prev, held_ex;
    logic [4:0]  held_code;
    int cycle_cnt = 0;
    int errors, test_errors, xfers, test_xfers, taken_seen, redirect_seen, ex_seen;
    int tests_run, tests_failed;
    int unsigned seed_val;

    fetch_frontend #(
        .reset_pc    (default_reset_pc),
        .btb_entries (btb_n)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // address hash that mixes all address bits
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e3779b1) ^ 32'h5a5a1234;
    endfunction

    assign inst_rdata = icache_busy ? 32'hdeadbeef : mem_word(mem_addr);

    always @(posedge clk) begin
        if (inst_req) begin
            mem_addr <= inst_addr;
        end
    end

    function automatic logic btb_hit(input logic [31:0] pc);
        return m_valid[pc[idx_w+1:2]] && m_tag[pc[idx_w+1:2]] == (pc >> (idx_w + 2));
    endfunction

    task automatic train_model(input logic [31:0] pc, input logic taken, input logic [31:0] tgt);
        int i;
        i = int'(pc[idx_w+1:2]);
        if (btb_hit(pc)) begin
            if (taken) begin
                m_target[i] = tgt;
                if (m_cnt[i] != 2'd3) m_cnt[i] = m_cnt[i] + 2'd1;
            end else if (m_cnt[i] != 2'd0) begin
                m_cnt[i] = m_cnt[i] - 2'd1;
            end
        end else if (taken) begin
            m_valid[i] = 1'b1;
            m_tag[i] = pc >> (idx_w + 2);
            m_target[i] = tgt;
            m_cnt[i] = 2'd2;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("MISMATCH t=%0t %s got=%h expected=%h", $time, name, got, want);
        errors++;
        test_errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_transfer();
        logic        ptaken;
        logic        ex;
        logic [31:0] want_inst;
        logic [4:0]  want_code;
        logic [31:0] next_pc;
        ptaken = btb_hit(exp_pc) && m_cnt[exp_pc[idx_w+1:2]] >= 2'd2;
        ex = |exp_pc[1:0];
        want_inst = ex ? 32'h0 : mem_word(exp_pc);
        want_code = ex ? exc_adel : 5'd0;
        // predicted next pc is the btb target or the following word
        next_pc = ptaken ? m_target[exp_pc[idx_w+1:2]] : exp_pc + 32'd4;
        if (xfers == 0) first_fs_pc = fs_pc;
        if (fs_pc !== exp_pc) report_mismatch("fs_pc", fs_pc, exp_pc);
        if (fs_inst !== want_inst) report_mismatch("fs_inst", fs_inst, want_inst);
        if (fs_ex !== ex) report_mismatch("fs_ex", fs_ex, ex);
        if (fs_exc_code !== want_code) report_mismatch("fs_exc_code", fs_exc_code, want_code);
        if (fs_pred_taken !== ptaken) report_mismatch("fs_pred_taken", fs_pred_taken, ptaken);
        if (fs_pred_target !== next_pc) begin
            report_mismatch("fs_pred_target", fs_pred_target, next_pc);
        end
        xfers++;
        test_xfers++;
        taken_seen += ptaken;
        ex_seen += ex;
        redirect_seen += squashed;
        squashed = 1'b0;
        last_pc = exp_pc;
        exp_pc = next_pc;
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            // held outputs must not move under back-pressure
            if (hold_prev && fs_to_ds_valid) begin
                if (fs_pc !== held_pc) report_mismatch("fs_pc (held)", fs_pc, held_pc);
                if (fs_inst !== held_inst) report_mismatch("fs_inst (held)", fs_inst, held_inst);
                if (fs_ex !== held_ex) report_mismatch("fs_ex (held)", fs_ex, held_ex);
                if (fs_exc_code !== held_code) begin
                    report_mismatch("fs_exc_code (held)", fs_exc_code, held_code);
                end
            end
            hold_prev = fs_to_ds_valid && !ds_allowin;
            held_pc = fs_pc;
            held_inst = fs_inst;
            held_ex = fs_ex;
            held_code = fs_exc_code;
            if (fs_to_ds_valid && ds_allowin) check_transfer();
            if (br_valid) train_model(br_pc, br_taken, br_target);
            if (flush || br_mispredict) begin
                exp_pc = flush ? exc_vector : br_target;
                squashed = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("ERROR timeout after %0d cycles", cycle_cnt);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic drive_cycle(input int kind);
        @(posedge clk);
        #1;
        icache_busy = ($urandom % 4) == 0;
        ds_allowin = ($urandom % 4) != 0;
        {flush, br_valid, br_taken, br_mispredict} = '0;
        // nearby pcs both behind and ahead of the path
        br_pc = last_pc + 32'(($urandom % 16) * 4) - 32'd32;
        br_target = last_pc + 32'(($urandom % 16) * 4) - 32'd32;
        if (kind == mode_pred && ($urandom % 10) < 3) begin
            br_valid = 1'b1;
            br_taken = ($urandom % 10) < 7;
        end else if ((kind == mode_misp || kind == mode_adel) && ($urandom % 12) == 0) begin
            br_valid = kind == mode_misp;
            br_taken = 1'b1;
            br_mispredict = 1'b1;
            br_target = default_reset_pc + 32'(($urandom % 256) * 4);
            if (kind == mode_adel) br_target = br_target + 32'(1 + $urandom % 3);
        end else if (kind == mode_flush && ($urandom % 16) == 0) begin
            flush = 1'b1;
        end
    endtask

    task automatic run_test(input string name, input int kind, input int cycles);
        {test_errors, test_xfers, taken_seen, redirect_seen, ex_seen} = '0;
        repeat (cycles) drive_cycle(kind);
        if (test_xfers == 0) report_error("no instruction was delivered");
        if (kind == mode_pred && taken_seen == 0) begin
            report_error("no taken prediction was delivered");
        end
        if ((kind == mode_misp || kind == mode_flush) && redirect_seen == 0) begin
            report_error("no redirected instruction was delivered");
        end
        if (kind == mode_adel && ex_seen == 0) report_error("no faulting fetch was delivered");
        tests_run++;
        tests_failed += (test_errors != 0);
        $display("test %-10s %0d transfers, %0d errors", name, test_xfers, test_errors);
    endtask

    initial begin
        seed_val = $urandom(32'he83);
        {reset, flush, br_valid, br_taken, br_mispredict, icache_busy} = 6'b100000;
        ds_allowin = 1'b1;
        br_pc = '0;
        br_target = '0;
        {errors, test_errors, xfers, test_xfers, tests_run, tests_failed} = '0;
        exp_pc = default_reset_pc;
        last_pc = default_reset_pc;
        mem_addr = '0;
        {squashed, hold_prev} = 2'b00;
        for (int i = 0; i < btb_n; i++) m_valid[i] = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1;
            if (fs_to_ds_valid !== 1'b0) report_error("fs_to_ds_valid high during reset");
        end
        reset = 1'b0;
        @(posedge clk);
        if (fs_to_ds_valid !== 1'b0) report_error("fs_to_ds_valid high right after reset");
        if (inst_req !== 1'b1) report_error("no request in the first cycle after reset");
        if (inst_addr !== default_reset_pc) report_mismatch("inst_addr", inst_addr, default_reset_pc);
        while (xfers == 0) drive_cycle(mode_seq);
        if (first_fs_pc !== default_reset_pc) begin
            report_mismatch("first fs_pc", first_fs_pc, default_reset_pc);
        end
        tests_run++;
        tests_failed += (test_errors != 0);
        $display("test %-10s %0d transfers, %0d errors", "reset", xfers, test_errors);
        run_test("sequential", mode_seq, seq_cycles);
        run_test("predictor", mode_pred, pred_cycles);
        run_test("mispredict", mode_misp, misp_cycles);
        run_test("flush", mode_flush, flush_cycles);
        run_test("addr_error", mode_adel, adel_cycles);
        $display("%0d tests, %0d failed, %0d transfers, %0d errors",
                 tests_run, tests_failed, xfers, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
design/fetch_pkg.sv
design/bpu.sv
design/pre_if_stage.sv
design/if_stage.sv
design/fetch_frontend.sv
verification/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - design/fetch_pkg.sv
  - design/bpu.sv
  - design/pre_if_stage.sv
  - design/if_stage.sv
  - design/fetch_frontend.sv
  - target: simulation
    files:
      - verification/fetch_tb.sv
